//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // ========================================
    // opcodes of the supported instructions.
    // ========================================
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // addi x0, x0, 0.
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // ALU_ADD must stay at zero so an all-zero control is a nop.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_t;

    // ========================================
    // stage structs.
    // ========================================
    typedef struct packed {
        alu_op_t alu_op;
        br_op_t  br_op;
        logic    src_a_pc;
        logic    src_b_imm;
        logic    reg_write;
        logic    link;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    instr;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

//--- design/fetch_unit.sv
`default_nettype none

module fetch_unit
    import rv_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            stall,
    input  wire redirect_t redirect,
    input  wire word_t     imem_data,
    output word_t          imem_addr,
    output if_id_t         if_id
);

    word_t pc;

    // the memory answers in the same cycle.
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            if_id <= '0;
        end else if (!stall) begin
            if (redirect.taken) begin
                // drop the word fetched down the wrong path.
                pc          <= redirect.target;
                if_id.valid <= 1'b0;
                if_id.pc    <= pc;
                if_id.instr <= NOP_INSTR;
            end else begin
                pc          <= pc + 32'd4;
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= imem_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- decode/register_file.sv
`default_nettype none

module register_file
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    input  wire wb_t      wb,
    output word_t         rs1_data,
    output word_t         rs2_data
);

    word_t regs [1:31];

    // x0 reads zero, a same-cycle write is passed straight through.
    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb.valid && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rs1_data = read_reg(rs1);
        rs2_data = read_reg(rs2);
    end

endmodule

`default_nettype wire

//--- decode/instruction_decoder.sv
`default_nettype none

module instruction_decoder
    import rv_pkg::*;
(
    input  wire word_t instr,
    output ctrl_t      ctrl,
    output imm_fmt_t   imm_fmt
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // instr[30] selects sub and sra.
    assign alt    = instr[30];

    // immediate forms have no sub, so alt only counts for register ops there.
    function automatic alu_op_t alu_from_funct(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       reg_op
    );
        case (f3)
            3'b000:  return (reg_op && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl    = '0;
        imm_fmt = IMM_I;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct(funct3, alt, 1'b1);
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = alu_from_funct(funct3, alt, 1'b0);
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm_fmt        = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm_fmt        = IMM_U;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.br_op     = BR_JAL;
                imm_fmt        = IMM_J;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.link      = 1'b1;
                    ctrl.br_op     = BR_JALR;
                end
            end
            OPC_BRANCH: begin
                imm_fmt = IMM_B;
                case (funct3)
                    3'b000:  ctrl.br_op = BR_BEQ;
                    3'b001:  ctrl.br_op = BR_BNE;
                    3'b100:  ctrl.br_op = BR_BLT;
                    3'b101:  ctrl.br_op = BR_BGE;
                    3'b110:  ctrl.br_op = BR_BLTU;
                    3'b111:  ctrl.br_op = BR_BGEU;
                    default: ctrl.br_op = BR_NONE;
                endcase
            end
            default: begin
                // unsupported, left as a nop.
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            stall,
    input  wire redirect_t redirect,
    input  wire if_id_t    if_id,
    input  wire wb_t       wb,
    output id_ex_t         id_ex
);

    ctrl_t    ctrl;
    imm_fmt_t imm_fmt;
    word_t    instr;
    word_t    imm;
    word_t    rs1_data;
    word_t    rs2_data;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     squash;
    id_ex_t   bubble;
    id_ex_t   next;

    assign instr = if_id.instr;
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];
    assign rd    = instr[11:7];

    // a flush or an empty fetch slot both turn into a nop.
    assign squash = redirect.taken || !if_id.valid;

    // ========================================
    // immediate generation.
    // ========================================
    always_comb begin
        case (imm_fmt)
            IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        bubble       = '0;
        bubble.instr = NOP_INSTR;
    end

    always_comb begin
        next.valid    = 1'b1;
        next.pc       = if_id.pc;
        next.instr    = instr;
        next.rs1_data = rs1_data;
        next.rs2_data = rs2_data;
        next.imm      = imm;
        next.rd       = rd;
        next.ctrl     = ctrl;
    end

    // ========================================
    // decode to execute register.
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= bubble;
        end else if (!stall) begin
            id_ex <= squash ? bubble : next;
        end
    end

    register_file u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    instruction_decoder u_instruction_decoder (
        .instr   (instr),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

endmodule

`default_nettype wire

//--- design/execute_unit.sv
`default_nettype none

module execute_unit
    import rv_pkg::*;
(
    input  wire         stall,
    input  wire id_ex_t id_ex,
    output wb_t         wb,
    output redirect_t   redirect
);

    ctrl_t      ctrl;
    word_t      op_a;
    word_t      op_b;
    word_t      rs1;
    word_t      rs2;
    word_t      alu_result;
    word_t      link_pc;
    logic [4:0] shamt;
    logic       cond;
    logic       active;

    assign ctrl  = id_ex.ctrl;
    assign rs1   = id_ex.rs1_data;
    assign rs2   = id_ex.rs2_data;
    assign op_a  = ctrl.src_a_pc ? id_ex.pc : rs1;
    assign op_b  = ctrl.src_b_imm ? id_ex.imm : rs2;
    assign shamt = op_b[4:0];

    // a stalled instruction waits and takes effect once the stall drops.
    assign active = id_ex.valid && !stall;

    // ========================================
    // ALU.
    // ========================================
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // branch compare always works on the two register values.
    always_comb begin
        case (ctrl.br_op)
            BR_BEQ:  cond = rs1 == rs2;
            BR_BNE:  cond = rs1 != rs2;
            BR_BLT:  cond = $signed(rs1) < $signed(rs2);
            BR_BGE:  cond = $signed(rs1) >= $signed(rs2);
            BR_BLTU: cond = rs1 < rs2;
            BR_BGEU: cond = rs1 >= rs2;
            BR_JAL:  cond = 1'b1;
            BR_JALR: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign link_pc = id_ex.pc + 32'd4;

    always_comb begin
        redirect.taken = active && cond;
        if (ctrl.br_op == BR_JALR) begin
            redirect.target = (rs1 + id_ex.imm) & ~32'd1;
        end else begin
            redirect.target = id_ex.pc + id_ex.imm;
        end
    end

    always_comb begin
        wb.valid = active && ctrl.reg_write && id_ex.rd != '0;
        wb.rd    = id_ex.rd;
        wb.data  = ctrl.link ? link_pc : alu_result;
    end

endmodule

`default_nettype wire

//--- design/rv32_core.sv
`default_nettype none

module rv32_core
    import rv_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        stall,
    input  wire word_t imem_data,
    output word_t      imem_addr,
    output wb_t        wb
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    redirect_t redirect;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .redirect  (redirect),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .if_id     (if_id)
    );

    // writeback also feeds the register file inside decode.
    decode_stage u_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .redirect (redirect),
        .if_id    (if_id),
        .wb       (wb),
        .id_ex    (id_ex)
    );

    execute_unit u_execute_unit (
        .stall    (stall),
        .id_ex    (id_ex),
        .wb       (wb),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

//--- sim/tb_rv32_core.sv
`default_nettype none

module tb_rv32_core;
    import rv_pkg::*;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int TAIL_CYCLES     = 4;
    localparam int RUN_LIMIT       = 80;
    localparam int STALL_RUN_LIMIT = 200;
    localparam int NUM_RUNS        = 5;
    // every run gets its reset and its cycle limit, plus a margin.
    localparam int WATCHDOG_CYCLES =
        NUM_RUNS * (RESET_CYCLES + 1) + 4 * RUN_LIMIT + STALL_RUN_LIMIT + 100;

    logic        clk;
    logic        rst_n;
    logic        stall;
    word_t       imem_data;
    word_t       imem_addr;
    wb_t         wb;

    word_t       imem [0:255];
    logic [7:0]  load_idx;
    wb_t         exp_q [$];
    logic [31:0] lcg_state;

    rv32_core #(
        .RESET_PC (32'h0000_0000)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb        (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // words outside the 1 KiB array read as nops.
    assign imem_data = (imem_addr[31:10] == '0) ? imem[imem_addr[9:2]] : NOP_INSTR;

    // ========================================
    // failure reporting and compares.
    // ========================================
    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic compare_wb(input string name, input wb_t got, input wb_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s (valid rd data) got %0b %0d %h expected %0b %0d %h",
                     $time, name, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
            abort_run();
        end
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ========================================
    // instruction encoding.
    // ========================================
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t cur_pc();
        return {22'b0, load_idx, 2'b00};
    endfunction

    // ========================================
    // program loading and running.
    // ========================================
    task automatic clear_program();
        foreach (imem[i]) begin
            imem[i] = NOP_INSTR;
        end
        load_idx = '0;
        exp_q.delete();
    endtask

    task automatic emit(input word_t instr);
        imem[load_idx] = instr;
        load_idx = load_idx + 8'd1;
    endtask

    task automatic expect_wb(input reg_idx_t rd, input word_t data);
        wb_t e;
        e.valid = 1'b1;
        e.rd    = rd;
        e.data  = data;
        exp_q.push_back(e);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        stall <= 1'b0;
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            compare_bit("wb.valid", wb.valid, 1'b0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // end_addr is the fetch address seen while the last write is in execute.
    task automatic run_program(input word_t end_addr, input int limit, input bit use_stall);
        int  cycles;
        int  tail;
        wb_t exp;
        cycles = 0;
        tail   = 0;
        while (tail < TAIL_CYCLES) begin
            @(posedge clk);
            if (use_stall) begin
                lcg_state = next_random(lcg_state);
                stall <= (lcg_state[31:29] < 3'd3);
            end else begin
                stall <= 1'b0;
            end
            @(negedge clk);
            if (stall) begin
                compare_bit("wb.valid", wb.valid, 1'b0);
            end else if (wb.valid) begin
                if (exp_q.size() == 0) begin
                    report_problem("a writeback appeared after the program had finished");
                end else begin
                    exp = exp_q.pop_front();
                    compare_wb("wb", wb, exp);
                    if (exp_q.size() == 0) begin
                        compare_word("imem_addr", imem_addr, end_addr);
                    end
                end
            end
            if (exp_q.size() == 0) begin
                tail++;
            end
            cycles++;
            if (cycles > limit) begin
                report_problem("expected writebacks did not arrive within the cycle limit");
            end
        end
    endtask

    // ========================================
    // directed tests.
    // ========================================
    task automatic reset_test();
        clear_program();
        // every slot writes a register, so any early writeback would show.
        for (int k = 0; k < 8; k++) begin
            emit(i_type(12'(k + 1), 5'd0, 3'b000, reg_idx_t'(k + 1), OPC_OP_IMM));
        end
        apply_reset();
        // the word fetched first reaches writeback two cycles later.
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            compare_word("imem_addr", imem_addr, word_t'(i) << 2);
            compare_bit("wb.valid", wb.valid, i >= 2);
        end
    endtask

    task automatic imm_chain_test();
        word_t v;
        clear_program();
        emit(i_type(12'hED4, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        v = 32'd0 + sext12(12'hED4);
        expect_wb(5'd1, v);
        emit(i_type(12'hFFB, 5'd1, 3'b010, 5'd2, OPC_OP_IMM));
        v = ($signed(v) < $signed(sext12(12'hFFB))) ? 32'd1 : 32'd0;
        expect_wb(5'd2, v);
        emit(i_type(12'h7F0, 5'd2, 3'b100, 5'd3, OPC_OP_IMM));
        v = v ^ sext12(12'h7F0);
        expect_wb(5'd3, v);
        emit(i_type(12'hF00, 5'd3, 3'b110, 5'd4, OPC_OP_IMM));
        v = v | sext12(12'hF00);
        expect_wb(5'd4, v);
        emit(i_type(12'h6AB, 5'd4, 3'b111, 5'd5, OPC_OP_IMM));
        v = v & sext12(12'h6AB);
        expect_wb(5'd5, v);
        emit(i_type({7'b0000000, 5'd21}, 5'd5, 3'b001, 5'd6, OPC_OP_IMM));
        v = v << 21;
        expect_wb(5'd6, v);
        // srai first while the value is still negative.
        emit(i_type({7'b0100000, 5'd4}, 5'd6, 3'b101, 5'd7, OPC_OP_IMM));
        v = $signed(v) >>> 4;
        expect_wb(5'd7, v);
        emit(i_type({7'b0000000, 5'd8}, 5'd7, 3'b101, 5'd8, OPC_OP_IMM));
        v = v >> 8;
        expect_wb(5'd8, v);
        // x0 is never written back.
        emit(i_type(12'd5, 5'd8, 3'b000, 5'd0, OPC_OP_IMM));
        emit(i_type(12'd1, 5'd8, 3'b000, 5'd9, OPC_OP_IMM));
        expect_wb(5'd9, v + 32'd1);
        apply_reset();
        run_program(cur_pc() + 32'd4, RUN_LIMIT, 1'b0);
    endtask

    task automatic load_reg_program(output word_t end_addr);
        word_t a;
        word_t b;
        clear_program();
        a = sext12(12'hFEC);
        b = 32'd3;
        emit(i_type(12'hFEC, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        expect_wb(5'd1, a);
        emit(i_type(12'd3, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        expect_wb(5'd2, b);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd4));
        expect_wb(5'd4, a + b);
        emit(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd5));
        expect_wb(5'd5, a - b);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b001, 5'd6));
        expect_wb(5'd6, a << b[4:0]);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd7));
        expect_wb(5'd7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b011, 5'd8));
        expect_wb(5'd8, (a < b) ? 32'd1 : 32'd0);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd9));
        expect_wb(5'd9, a ^ b);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b101, 5'd10));
        expect_wb(5'd10, a >> b[4:0]);
        emit(r_type(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd11));
        expect_wb(5'd11, $signed(a) >>> b[4:0]);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd12));
        expect_wb(5'd12, a | b);
        emit(r_type(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd13));
        expect_wb(5'd13, a & b);
        // positive first operand against the negative one.
        emit(r_type(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd14));
        expect_wb(5'd14, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        emit(r_type(7'b0000000, 5'd1, 5'd2, 3'b011, 5'd15));
        expect_wb(5'd15, (b < a) ? 32'd1 : 32'd0);
        emit(u_type(20'hABCDE, 5'd16, OPC_LUI));
        expect_wb(5'd16, {20'hABCDE, 12'h000});
        expect_wb(5'd17, cur_pc() + {20'h12345, 12'h000});
        emit(u_type(20'h12345, 5'd17, OPC_AUIPC));
        end_addr = cur_pc() + 32'd4;
    endtask

    task automatic reg_ops_test();
        word_t end_addr;
        load_reg_program(end_addr);
        apply_reset();
        run_program(end_addr, RUN_LIMIT, 1'b0);
    endtask

    task automatic control_flow_test();
        clear_program();
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        expect_wb(5'd1, 32'd5);
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        expect_wb(5'd2, 32'd5);
        // beq taken over two instructions.
        emit(b_type(13'd12, 5'd2, 5'd1, 3'b000));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        emit(b_type(13'd12, 5'd0, 5'd1, 3'b001));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
        // blt with equal operands falls through.
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b100));
        emit(i_type(12'd3, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
        expect_wb(5'd5, 32'd3);
        expect_wb(5'd6, cur_pc() + 32'd4);
        emit(j_type(21'd12, 5'd6));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        emit(i_type(12'd65, 5'd0, 3'b000, 5'd8, OPC_OP_IMM));
        expect_wb(5'd8, 32'd65);
        // jalr target 65 + 4 = 69 lands on 68 once bit 0 is cleared.
        expect_wb(5'd9, cur_pc() + 32'd4);
        emit(i_type(12'd4, 5'd8, 3'b000, 5'd9, OPC_JALR));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        emit(i_type(12'd9, 5'd0, 3'b000, 5'd11, OPC_OP_IMM));
        expect_wb(5'd11, 32'd9);
        apply_reset();
        run_program(cur_pc() + 32'd4, RUN_LIMIT, 1'b0);
    endtask

    task automatic stall_test();
        word_t end_addr;
        load_reg_program(end_addr);
        apply_reset();
        run_program(end_addr, STALL_RUN_LIMIT, 1'b1);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        stall     = 1'b0;
        lcg_state = 32'h7799_c4c2;
        clear_program();
        reset_test();
        imm_chain_test();
        reg_ops_test();
        control_flow_test();
        stall_test();
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: the run timed out before all tests finished");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- project.f
common/rv_pkg.sv
design/fetch_unit.sv
decode/register_file.sv
decode/instruction_decoder.sv
decode/decode_stage.sv
design/execute_unit.sv
design/rv32_core.sv
sim/tb_rv32_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide the result from the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv32_core -f project.f \
    -Mdir obj_dir -o tb_rv32_core > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_rv32_core > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
